// File: ao_periph_cfg.svh
/*
 * Always-on peripheral configuration: page map, register offsets and sizes
 */
`ifndef AO_PERIPH_CFG_SVH
`define AO_PERIPH_CFG_SVH

// Address bits that pick a peripheral page
`define AO_PAGE_LSB 12
`define AO_PAGE_MSB 15

`define SOC_CTRL_PAGE  4'd0
`define FAST_INTR_PAGE 4'd1
`define GPIO_PAGE      4'd2

`define NUM_FAST_INTR 15
`define NUM_GPIO      8

// SoC control
`define SOC_EXIT_VALID_OFFSET  12'h000
`define SOC_EXIT_VALUE_OFFSET  12'h004
`define SOC_BOOT_SELECT_OFFSET 12'h008

// Fast interrupt controller
`define FIC_PENDING_OFFSET 12'h000
`define FIC_CLEAR_OFFSET   12'h004
`define FIC_ENABLE_OFFSET  12'h008

// GPIO
`define GPIO_IN_OFFSET          12'h000
`define GPIO_OUT_OFFSET         12'h004
`define GPIO_OUT_EN_OFFSET      12'h008
`define GPIO_INTR_EN_OFFSET     12'h00C
`define GPIO_INTR_STATUS_OFFSET 12'h010

`endif

// File: ao_periph_pkg.sv
/*
 * Always-on peripheral types: bus widths, interrupt and pin vectors, bridge states
 */
`include "ao_periph_cfg.svh"

package ao_periph_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  typedef logic [1:0]  sel_t;

  typedef logic [`NUM_FAST_INTR-1:0] fast_intr_t;
  typedef logic [`NUM_GPIO-1:0]      gpio_t;

  typedef enum logic [1:0] {IDLE, ACCESS, RESP} bridge_state_e;

  // Byte lanes with a strobe take the new data
  function automatic data_t strb_merge(data_t old_d, data_t new_d, strb_t strb);
    data_t res;
    res = old_d;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i+:8] = new_d[8*i+:8];
      end
    end
    return res;
  endfunction

endpackage

// File: ao_peripheral_subsystem.sv
/*
 * Always-on peripheral subsystem: OBI slave port, register bus demux,
 * SoC control, fast interrupt controller and GPIO
 */
`timescale 1ns/1ps

module ao_peripheral_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      slave_req_i,
  input  logic                      slave_we_i,
  input  ao_periph_pkg::addr_t      slave_addr_i,
  input  ao_periph_pkg::data_t      slave_wdata_i,
  input  ao_periph_pkg::strb_t      slave_be_i,
  output logic                      slave_gnt_o,
  output logic                      slave_rvalid_o,
  output ao_periph_pkg::data_t      slave_rdata_o,
  output logic                      slave_err_o,
  input  logic                      boot_select_i,
  output logic                      exit_valid_o,
  output ao_periph_pkg::data_t      exit_value_o,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output ao_periph_pkg::fast_intr_t fast_intr_o,
  input  ao_periph_pkg::gpio_t      cio_gpio_i,
  output ao_periph_pkg::gpio_t      cio_gpio_o,
  output ao_periph_pkg::gpio_t      cio_gpio_en_o,
  output ao_periph_pkg::gpio_t      intr_gpio_o
);

  // Bridge to demux
  logic                 reg_valid;
  logic                 reg_write;
  ao_periph_pkg::addr_t reg_addr;
  ao_periph_pkg::data_t reg_wdata;
  ao_periph_pkg::strb_t reg_wstrb;
  ao_periph_pkg::data_t reg_rdata;
  logic                 reg_error;
  logic                 reg_ready;

  // Demux to peripherals
  logic                 soc_valid;
  logic                 fic_valid;
  logic                 gpio_valid;
  logic                 per_write;
  ao_periph_pkg::addr_t per_addr;
  ao_periph_pkg::data_t per_wdata;
  ao_periph_pkg::strb_t per_wstrb;
  ao_periph_pkg::data_t soc_rdata;
  ao_periph_pkg::data_t fic_rdata;
  ao_periph_pkg::data_t gpio_rdata;

  obi_reg_bridge obi_reg_bridge_i (
    .clk_i,
    .rst_i,
    .slave_req_i,
    .slave_we_i,
    .slave_addr_i,
    .slave_wdata_i,
    .slave_be_i,
    .slave_gnt_o,
    .slave_rvalid_o,
    .slave_rdata_o,
    .slave_err_o,
    .reg_valid_o(reg_valid),
    .reg_write_o(reg_write),
    .reg_addr_o (reg_addr),
    .reg_wdata_o(reg_wdata),
    .reg_wstrb_o(reg_wstrb),
    .reg_rdata_i(reg_rdata),
    .reg_error_i(reg_error),
    .reg_ready_i(reg_ready)
  );

  ao_reg_demux ao_reg_demux_i (
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_wstrb_i (reg_wstrb),
    .reg_rdata_o (reg_rdata),
    .reg_error_o (reg_error),
    .reg_ready_o (reg_ready),
    .soc_valid_o (soc_valid),
    .fic_valid_o (fic_valid),
    .gpio_valid_o(gpio_valid),
    .write_o     (per_write),
    .addr_o      (per_addr),
    .wdata_o     (per_wdata),
    .wstrb_o     (per_wstrb),
    .soc_rdata_i (soc_rdata),
    .fic_rdata_i (fic_rdata),
    .gpio_rdata_i(gpio_rdata)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_i,
    .valid_i(soc_valid),
    .write_i(per_write),
    .addr_i (per_addr),
    .wdata_i(per_wdata),
    .wstrb_i(per_wstrb),
    .boot_select_i,
    .rdata_o(soc_rdata),
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_i,
    .valid_i(fic_valid),
    .write_i(per_write),
    .addr_i (per_addr),
    .wdata_i(per_wdata),
    .wstrb_i(per_wstrb),
    .fast_intr_i,
    .rdata_o(fic_rdata),
    .fast_intr_o
  );

  gpio_ao gpio_ao_i (
    .clk_i,
    .rst_i,
    .valid_i(gpio_valid),
    .write_i(per_write),
    .addr_i (per_addr),
    .wdata_i(per_wdata),
    .wstrb_i(per_wstrb),
    .cio_gpio_i,
    .rdata_o(gpio_rdata),
    .cio_gpio_o,
    .cio_gpio_en_o,
    .intr_gpio_o
  );

endmodule

// File: ao_reg_demux.sv
/*
 * Register bus demux: page decode, request routing and response select
 */
`timescale 1ns/1ps
`include "ao_periph_cfg.svh"

module ao_reg_demux (
  input  logic                 reg_valid_i,
  input  logic                 reg_write_i,
  input  ao_periph_pkg::addr_t reg_addr_i,
  input  ao_periph_pkg::data_t reg_wdata_i,
  input  ao_periph_pkg::strb_t reg_wstrb_i,
  output ao_periph_pkg::data_t reg_rdata_o,
  output logic                 reg_error_o,
  output logic                 reg_ready_o,
  output logic                 soc_valid_o,
  output logic                 fic_valid_o,
  output logic                 gpio_valid_o,
  output logic                 write_o,
  output ao_periph_pkg::addr_t addr_o,
  output ao_periph_pkg::data_t wdata_o,
  output ao_periph_pkg::strb_t wstrb_o,
  input  ao_periph_pkg::data_t soc_rdata_i,
  input  ao_periph_pkg::data_t fic_rdata_i,
  input  ao_periph_pkg::data_t gpio_rdata_i
);

  logic [`AO_PAGE_MSB-`AO_PAGE_LSB:0] page;
  ao_periph_pkg::sel_t                sel;
  logic                               hit;

  assign page = reg_addr_i[`AO_PAGE_MSB:`AO_PAGE_LSB];

  always_comb begin
    sel = 2'd0;
    hit = 1'b1;
    case (page)
      `SOC_CTRL_PAGE:  sel = 2'd0;
      `FAST_INTR_PAGE: sel = 2'd1;
      `GPIO_PAGE:      sel = 2'd2;
      default:         hit = 1'b0;
    endcase
  end

  assign soc_valid_o  = reg_valid_i & hit & (sel == 2'd0);
  assign fic_valid_o  = reg_valid_i & hit & (sel == 2'd1);
  assign gpio_valid_o = reg_valid_i & hit & (sel == 2'd2);

  assign write_o = reg_write_i;
  assign addr_o  = reg_addr_i;
  assign wdata_o = reg_wdata_i;
  assign wstrb_o = reg_wstrb_i;

  // Unmapped pages still complete, with an error
  assign reg_ready_o = reg_valid_i;
  assign reg_error_o = reg_valid_i & ~hit;

  always_comb begin
    reg_rdata_o = '0;
    if (hit) begin
      case (sel)
        2'd0:    reg_rdata_o = soc_rdata_i;
        2'd1:    reg_rdata_o = fic_rdata_i;
        2'd2:    reg_rdata_o = gpio_rdata_i;
        default: reg_rdata_o = '0;
      endcase
    end
  end

endmodule

// File: build.f
+incdir+.
ao_periph_pkg.sv
obi_reg_bridge.sv
ao_reg_demux.sv
soc_ctrl.sv
fast_intr_ctrl.sv
gpio_ao.sv
ao_peripheral_subsystem.sv
tb_ao_peripheral_subsystem.sv

// File: fast_intr_ctrl.sv
/*
 * Fast interrupt controller: latched pending lines, enable mask, write-one clear
 */
`timescale 1ns/1ps
`include "ao_periph_cfg.svh"

module fast_intr_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_i,
  input  logic                      valid_i,
  input  logic                      write_i,
  input  ao_periph_pkg::addr_t      addr_i,
  input  ao_periph_pkg::data_t      wdata_i,
  input  ao_periph_pkg::strb_t      wstrb_i,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output ao_periph_pkg::data_t      rdata_o,
  output ao_periph_pkg::fast_intr_t fast_intr_o
);

  logic [`AO_PAGE_LSB-1:0]   offset;
  logic                      wr_en;
  ao_periph_pkg::fast_intr_t pending_q;
  ao_periph_pkg::fast_intr_t enable_q;
  ao_periph_pkg::fast_intr_t clear_mask;
  ao_periph_pkg::data_t      enable_wr;
  ao_periph_pkg::data_t      clear_wr;

  assign offset = addr_i[`AO_PAGE_LSB-1:0];
  assign wr_en  = valid_i & write_i;

  assign enable_wr = ao_periph_pkg::strb_merge(ao_periph_pkg::data_t'(enable_q),
                                               wdata_i, wstrb_i);
  assign clear_wr  = ao_periph_pkg::strb_merge('0, wdata_i, wstrb_i);

  assign clear_mask = (wr_en && offset == `FIC_CLEAR_OFFSET) ?
                      ao_periph_pkg::fast_intr_t'(clear_wr) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // An active line wins over its own clear
      pending_q <= (pending_q & ~clear_mask) | fast_intr_i;
      if (wr_en && offset == `FIC_ENABLE_OFFSET) begin
        enable_q <= ao_periph_pkg::fast_intr_t'(enable_wr);
      end
    end
  end

  always_comb begin
    case (offset)
      `FIC_PENDING_OFFSET: rdata_o = ao_periph_pkg::data_t'(pending_q);
      `FIC_ENABLE_OFFSET:  rdata_o = ao_periph_pkg::data_t'(enable_q);
      default:             rdata_o = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

// File: gpio_ao.sv
/*
 * Always-on GPIO: output and enable registers, synchronised input, edge interrupts
 */
`timescale 1ns/1ps
`include "ao_periph_cfg.svh"

module gpio_ao (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  logic                 write_i,
  input  ao_periph_pkg::addr_t addr_i,
  input  ao_periph_pkg::data_t wdata_i,
  input  ao_periph_pkg::strb_t wstrb_i,
  input  ao_periph_pkg::gpio_t cio_gpio_i,
  output ao_periph_pkg::data_t rdata_o,
  output ao_periph_pkg::gpio_t cio_gpio_o,
  output ao_periph_pkg::gpio_t cio_gpio_en_o,
  output ao_periph_pkg::gpio_t intr_gpio_o
);

  logic [`AO_PAGE_LSB-1:0] offset;
  logic                    wr_en;
  ao_periph_pkg::gpio_t    in_meta_q;
  ao_periph_pkg::gpio_t    in_sync_q;
  ao_periph_pkg::gpio_t    in_prev_q;
  ao_periph_pkg::gpio_t    out_q;
  ao_periph_pkg::gpio_t    out_en_q;
  ao_periph_pkg::gpio_t    intr_en_q;
  ao_periph_pkg::gpio_t    status_q;
  ao_periph_pkg::gpio_t    rise;
  ao_periph_pkg::gpio_t    clear_mask;
  ao_periph_pkg::data_t    wr_merged;

  assign offset = addr_i[`AO_PAGE_LSB-1:0];
  assign wr_en  = valid_i & write_i;

  // Two-flop synchroniser, third flop for edge detection
  always_ff @(posedge clk_i) begin
    in_meta_q <= cio_gpio_i;
    in_sync_q <= in_meta_q;
    in_prev_q <= in_sync_q;
  end

  assign rise = in_sync_q & ~in_prev_q & intr_en_q;

  // Merge base is zero, which serves the write-one clear directly
  assign wr_merged  = ao_periph_pkg::strb_merge('0, wdata_i, wstrb_i);
  assign clear_mask = (wr_en && offset == `GPIO_INTR_STATUS_OFFSET) ?
                      ao_periph_pkg::gpio_t'(wr_merged) : '0;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_q     <= '0;
      out_en_q  <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      status_q <= (status_q & ~clear_mask) | rise;
      if (wr_en && wstrb_i[0]) begin
        case (offset)
          `GPIO_OUT_OFFSET:     out_q     <= ao_periph_pkg::gpio_t'(wr_merged);
          `GPIO_OUT_EN_OFFSET:  out_en_q  <= ao_periph_pkg::gpio_t'(wr_merged);
          `GPIO_INTR_EN_OFFSET: intr_en_q <= ao_periph_pkg::gpio_t'(wr_merged);
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset)
      `GPIO_IN_OFFSET:          rdata_o = ao_periph_pkg::data_t'(in_sync_q);
      `GPIO_OUT_OFFSET:         rdata_o = ao_periph_pkg::data_t'(out_q);
      `GPIO_OUT_EN_OFFSET:      rdata_o = ao_periph_pkg::data_t'(out_en_q);
      `GPIO_INTR_EN_OFFSET:     rdata_o = ao_periph_pkg::data_t'(intr_en_q);
      `GPIO_INTR_STATUS_OFFSET: rdata_o = ao_periph_pkg::data_t'(status_q);
      default:                  rdata_o = '0;
    endcase
  end

  assign cio_gpio_o    = out_q;
  assign cio_gpio_en_o = out_en_q;
  assign intr_gpio_o   = status_q;

endmodule

// File: obi_reg_bridge.sv
/*
 * OBI to register bus bridge
 * One request in flight, response two cycles after grant
 */
`timescale 1ns/1ps

module obi_reg_bridge (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 slave_req_i,
  input  logic                 slave_we_i,
  input  ao_periph_pkg::addr_t slave_addr_i,
  input  ao_periph_pkg::data_t slave_wdata_i,
  input  ao_periph_pkg::strb_t slave_be_i,
  output logic                 slave_gnt_o,
  output logic                 slave_rvalid_o,
  output ao_periph_pkg::data_t slave_rdata_o,
  output logic                 slave_err_o,
  output logic                 reg_valid_o,
  output logic                 reg_write_o,
  output ao_periph_pkg::addr_t reg_addr_o,
  output ao_periph_pkg::data_t reg_wdata_o,
  output ao_periph_pkg::strb_t reg_wstrb_o,
  input  ao_periph_pkg::data_t reg_rdata_i,
  input  logic                 reg_error_i,
  input  logic                 reg_ready_i
);

  ao_periph_pkg::bridge_state_e state_q;

  logic                 we_q;
  ao_periph_pkg::addr_t addr_q;
  ao_periph_pkg::data_t wdata_q;
  ao_periph_pkg::strb_t be_q;
  ao_periph_pkg::data_t rdata_q;
  logic                 err_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ao_periph_pkg::IDLE;
    end else begin
      case (state_q)
        ao_periph_pkg::IDLE: begin
          if (slave_req_i) begin
            state_q <= ao_periph_pkg::ACCESS;
          end
        end
        ao_periph_pkg::ACCESS: begin
          if (reg_ready_i) begin
            state_q <= ao_periph_pkg::RESP;
          end
        end
        default: state_q <= ao_periph_pkg::IDLE;
      endcase
    end
  end

  // Request captured on grant, response captured on ready
  always_ff @(posedge clk_i) begin
    if (slave_gnt_o && slave_req_i) begin
      we_q    <= slave_we_i;
      addr_q  <= slave_addr_i;
      wdata_q <= slave_wdata_i;
      be_q    <= slave_be_i;
    end
    if (reg_valid_o && reg_ready_i) begin
      rdata_q <= reg_rdata_i;
      err_q   <= reg_error_i;
    end
  end

  assign slave_gnt_o    = (state_q == ao_periph_pkg::IDLE);
  assign reg_valid_o    = (state_q == ao_periph_pkg::ACCESS);
  assign slave_rvalid_o = (state_q == ao_periph_pkg::RESP);
  assign slave_rdata_o  = rdata_q;
  assign slave_err_o    = err_q;

  assign reg_write_o = we_q;
  assign reg_addr_o  = addr_q;
  assign reg_wdata_o = wdata_q;
  assign reg_wstrb_o = be_q;

  // Grant stays low until the response, which never overlaps a grant
  assert property (@(posedge clk_i) disable iff (rst_i)
    slave_req_i && slave_gnt_o |=> !slave_gnt_o ##1 (slave_rvalid_o && !slave_gnt_o))
    else $error("OBI response not two cycles after grant");

  // Peripherals answer in the access cycle
  assert property (@(posedge clk_i) disable iff (rst_i) reg_valid_o |-> reg_ready_i)
    else $error("register access without ready");

endmodule

// File: soc_ctrl.sv
/*
 * SoC control: exit value and exit flag, boot-select status
 */
`timescale 1ns/1ps
`include "ao_periph_cfg.svh"

module soc_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  input  logic                 write_i,
  input  ao_periph_pkg::addr_t addr_i,
  input  ao_periph_pkg::data_t wdata_i,
  input  ao_periph_pkg::strb_t wstrb_i,
  input  logic                 boot_select_i,
  output ao_periph_pkg::data_t rdata_o,
  output logic                 exit_valid_o,
  output ao_periph_pkg::data_t exit_value_o
);

  logic [`AO_PAGE_LSB-1:0] offset;
  logic                    wr_en;
  logic                    exit_valid_q;
  ao_periph_pkg::data_t    exit_value_q;
  logic                    boot_select_q;

  assign offset = addr_i[`AO_PAGE_LSB-1:0];
  assign wr_en  = valid_i & write_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (offset)
        `SOC_EXIT_VALID_OFFSET: begin
          // Flag lives in bit 0, so only lane 0 matters
          if (wstrb_i[0]) begin
            exit_valid_q <= wdata_i[0];
          end
        end
        `SOC_EXIT_VALUE_OFFSET: begin
          exit_value_q <= ao_periph_pkg::strb_merge(exit_value_q, wdata_i, wstrb_i);
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    boot_select_q <= boot_select_i;
  end

  always_comb begin
    case (offset)
      `SOC_EXIT_VALID_OFFSET:  rdata_o = {31'b0, exit_valid_q};
      `SOC_EXIT_VALUE_OFFSET:  rdata_o = exit_value_q;
      `SOC_BOOT_SELECT_OFFSET: rdata_o = {31'b0, boot_select_q};
      default:                 rdata_o = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// File: tb_ao_peripheral_subsystem.sv
/*
 * Testbench for the always-on peripheral subsystem: directed OBI accesses
 * against SoC control, fast interrupts, GPIO and an unmapped page
 */
`timescale 1ns/1ps
`include "ao_periph_cfg.svh"

module tb_ao_peripheral_subsystem;

  localparam int CLK_NS        = 4;
  localparam int RESET_CYCLES  = 3;
  localparam int NUM_ACCESSES  = 50;
  localparam int ACCESS_CYCLES = 4;
  localparam int WAIT_CYCLES   = 40;
  localparam int TIMEOUT_NS    =
    2 * (RESET_CYCLES + NUM_ACCESSES * ACCESS_CYCLES + WAIT_CYCLES) * CLK_NS;

  logic                      clk_i;
  logic                      rst_i;
  logic                      slave_req_i;
  logic                      slave_we_i;
  ao_periph_pkg::addr_t      slave_addr_i;
  ao_periph_pkg::data_t      slave_wdata_i;
  ao_periph_pkg::strb_t      slave_be_i;
  logic                      slave_gnt_o;
  logic                      slave_rvalid_o;
  ao_periph_pkg::data_t      slave_rdata_o;
  logic                      slave_err_o;
  logic                      boot_select_i;
  logic                      exit_valid_o;
  ao_periph_pkg::data_t      exit_value_o;
  ao_periph_pkg::fast_intr_t fast_intr_i;
  ao_periph_pkg::fast_intr_t fast_intr_o;
  ao_periph_pkg::gpio_t      cio_gpio_i;
  ao_periph_pkg::gpio_t      cio_gpio_o;
  ao_periph_pkg::gpio_t      cio_gpio_en_o;
  ao_periph_pkg::gpio_t      intr_gpio_o;

  integer               seed;
  int                   grant_wait;
  ao_periph_pkg::data_t exit_value_exp;

  ao_peripheral_subsystem dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_NS / 2) clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("test failed");
    $fatal(1, "simulation stopped");
  endtask

  function automatic ao_periph_pkg::addr_t reg_addr(input logic [3:0] page,
                                                    input logic [11:0] offset);
    return {16'h0000, page, offset};
  endfunction

  // Bit mask of the strobed byte lanes
  function automatic ao_periph_pkg::data_t lane_mask(input ao_periph_pkg::strb_t be);
    ao_periph_pkg::data_t m;
    for (int i = 0; i < 4; i++) begin
      m[8*i+:8] = {8{be[i]}};
    end
    return m;
  endfunction

  task automatic check_data(input string what, input ao_periph_pkg::data_t got,
                            input ao_periph_pkg::data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s is 0x%08h, expected 0x%08h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_gpio(input string what, input ao_periph_pkg::gpio_t got,
                            input ao_periph_pkg::gpio_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s is 0x%02h, expected 0x%02h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_fast_intr(input string what, input ao_periph_pkg::fast_intr_t got,
                                 input ao_periph_pkg::fast_intr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s is 0x%04h, expected 0x%04h",
                          $time, what, got, exp));
    end
  endtask

  task automatic check_err(input string what, input bit got, input bit exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error at %0t ns: %s is %0b, expected %0b",
                          $time, what, got, exp));
    end
  endtask

  // One OBI transaction, sampled at falling edges
  task automatic obi_access(input bit we, input ao_periph_pkg::addr_t addr,
                            input ao_periph_pkg::data_t wdata,
                            input ao_periph_pkg::strb_t be, input bit exp_err,
                            output ao_periph_pkg::data_t rdata);
    int waited;
    waited = 0;
    @(posedge clk_i);
    slave_req_i   <= 1'b1;
    slave_we_i    <= we;
    slave_addr_i  <= addr;
    slave_wdata_i <= wdata;
    slave_be_i    <= be;
    @(negedge clk_i);
    while (!slave_gnt_o) begin
      waited++;
      if (waited > 8) begin
        abort_run($sformatf("Request to 0x%08h was never granted", addr));
      end
      @(negedge clk_i);
    end
    grant_wait = waited;
    @(posedge clk_i);
    slave_req_i <= 1'b0;
    @(negedge clk_i);
    if (slave_gnt_o || slave_rvalid_o) begin
      abort_run($sformatf("Grant or response seen one cycle after grant at %0t ns", $time));
    end
    @(negedge clk_i);
    if (slave_gnt_o || !slave_rvalid_o) begin
      abort_run($sformatf("No response two cycles after grant at %0t ns", $time));
    end
    check_err($sformatf("error flag for 0x%08h", addr), slave_err_o, exp_err);
    rdata = slave_rdata_o;
  endtask

  task automatic obi_write(input ao_periph_pkg::addr_t addr, input ao_periph_pkg::data_t data,
                           input ao_periph_pkg::strb_t be, input bit exp_err);
    ao_periph_pkg::data_t unused;
    obi_access(1'b1, addr, data, be, exp_err, unused);
  endtask

  task automatic obi_read(input ao_periph_pkg::addr_t addr, input bit exp_err,
                          output ao_periph_pkg::data_t data);
    obi_access(1'b0, addr, '0, 4'hf, exp_err, data);
  endtask

  task automatic read_check(input string what, input ao_periph_pkg::addr_t addr,
                            input ao_periph_pkg::data_t exp);
    ao_periph_pkg::data_t got;
    obi_read(addr, 1'b0, got);
    check_data(what, got, exp);
  endtask

  task automatic test_reset_state();
    @(negedge clk_i);
    check_err("slave_gnt_o", slave_gnt_o, 1'b1);
    check_err("slave_rvalid_o", slave_rvalid_o, 1'b0);
    check_err("exit_valid_o", exit_valid_o, 1'b0);
    check_data("exit_value_o", exit_value_o, '0);
    check_fast_intr("fast_intr_o", fast_intr_o, '0);
    check_gpio("cio_gpio_o", cio_gpio_o, '0);
    check_gpio("cio_gpio_en_o", cio_gpio_en_o, '0);
    check_gpio("intr_gpio_o", intr_gpio_o, '0);
    read_check("EXIT_VALID", reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALID_OFFSET), '0);
    read_check("EXIT_VALUE", reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALUE_OFFSET), '0);
    read_check("BOOT_SELECT", reg_addr(`SOC_CTRL_PAGE, `SOC_BOOT_SELECT_OFFSET),
               ao_periph_pkg::data_t'(boot_select_i));
    read_check("PENDING", reg_addr(`FAST_INTR_PAGE, `FIC_PENDING_OFFSET), '0);
    read_check("CLEAR", reg_addr(`FAST_INTR_PAGE, `FIC_CLEAR_OFFSET), '0);
    read_check("ENABLE", reg_addr(`FAST_INTR_PAGE, `FIC_ENABLE_OFFSET), '0);
    read_check("IN", reg_addr(`GPIO_PAGE, `GPIO_IN_OFFSET),
               ao_periph_pkg::data_t'(cio_gpio_i));
    read_check("OUT", reg_addr(`GPIO_PAGE, `GPIO_OUT_OFFSET), '0);
    read_check("OUT_EN", reg_addr(`GPIO_PAGE, `GPIO_OUT_EN_OFFSET), '0);
    read_check("INTR_EN", reg_addr(`GPIO_PAGE, `GPIO_INTR_EN_OFFSET), '0);
    read_check("INTR_STATUS", reg_addr(`GPIO_PAGE, `GPIO_INTR_STATUS_OFFSET), '0);
  endtask

  task automatic test_soc_ctrl();
    ao_periph_pkg::data_t value;
    ao_periph_pkg::data_t patch;
    ao_periph_pkg::strb_t be;
    value = $random(seed);
    obi_write(reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALUE_OFFSET), value, 4'hf, 1'b0);
    read_check("EXIT_VALUE", reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALUE_OFFSET), value);
    // Lanes 0 and 2 only
    patch = $random(seed);
    be    = 4'b0101;
    exit_value_exp = (value & ~lane_mask(be)) | (patch & lane_mask(be));
    obi_write(reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALUE_OFFSET), patch, be, 1'b0);
    read_check("EXIT_VALUE after partial write",
               reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALUE_OFFSET), exit_value_exp);
    check_err("exit_valid_o before flag write", exit_valid_o, 1'b0);
    obi_write(reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALID_OFFSET), 32'h1, 4'h1, 1'b0);
    check_err("exit_valid_o", exit_valid_o, 1'b1);
    check_data("exit_value_o", exit_value_o, exit_value_exp);
    read_check("EXIT_VALID", reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALID_OFFSET), 32'h1);
    @(posedge clk_i);
    boot_select_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    read_check("BOOT_SELECT", reg_addr(`SOC_CTRL_PAGE, `SOC_BOOT_SELECT_OFFSET), '0);
  endtask

  task automatic test_gpio();
    ao_periph_pkg::gpio_t out_v;
    ao_periph_pkg::gpio_t en_v;
    ao_periph_pkg::gpio_t pins;
    out_v = $random(seed);
    en_v  = $random(seed);
    obi_write(reg_addr(`GPIO_PAGE, `GPIO_OUT_OFFSET), 32'(out_v), 4'hf, 1'b0);
    obi_write(reg_addr(`GPIO_PAGE, `GPIO_OUT_EN_OFFSET), 32'(en_v), 4'hf, 1'b0);
    check_gpio("cio_gpio_o", cio_gpio_o, out_v);
    check_gpio("cio_gpio_en_o", cio_gpio_en_o, en_v);
    read_check("OUT", reg_addr(`GPIO_PAGE, `GPIO_OUT_OFFSET), 32'(out_v));
    read_check("OUT_EN", reg_addr(`GPIO_PAGE, `GPIO_OUT_EN_OFFSET), 32'(en_v));
    pins = $random(seed);
    @(posedge clk_i);
    cio_gpio_i <= pins;
    repeat (3) @(posedge clk_i);
    read_check("IN", reg_addr(`GPIO_PAGE, `GPIO_IN_OFFSET), 32'(pins));
    // Pins low, then a rise on bit 0 (enabled) and bit 4 (disabled)
    @(posedge clk_i);
    cio_gpio_i <= '0;
    repeat (3) @(posedge clk_i);
    obi_write(reg_addr(`GPIO_PAGE, `GPIO_INTR_EN_OFFSET), 32'h0f, 4'h1, 1'b0);
    check_gpio("intr_gpio_o without edge", intr_gpio_o, '0);
    @(posedge clk_i);
    cio_gpio_i <= 8'h11;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    check_gpio("intr_gpio_o after rising edge", intr_gpio_o, 8'h01);
    read_check("INTR_STATUS", reg_addr(`GPIO_PAGE, `GPIO_INTR_STATUS_OFFSET), 32'h01);
    obi_write(reg_addr(`GPIO_PAGE, `GPIO_INTR_STATUS_OFFSET), 32'h01, 4'h1, 1'b0);
    check_gpio("intr_gpio_o after clear", intr_gpio_o, '0);
    read_check("INTR_STATUS after clear", reg_addr(`GPIO_PAGE, `GPIO_INTR_STATUS_OFFSET), '0);
  endtask

  task automatic test_fast_intr();
    ao_periph_pkg::fast_intr_t en;
    ao_periph_pkg::fast_intr_t pulse;
    ao_periph_pkg::fast_intr_t held;
    en    = 15'h0155;
    pulse = 15'h0f0f;
    held  = 15'h0100;
    obi_write(reg_addr(`FAST_INTR_PAGE, `FIC_ENABLE_OFFSET), 32'(en), 4'hf, 1'b0);
    @(posedge clk_i);
    fast_intr_i <= pulse;
    @(posedge clk_i);
    fast_intr_i <= held;
    @(negedge clk_i);
    check_fast_intr("fast_intr_o after pulse", fast_intr_o, pulse & en);
    read_check("PENDING", reg_addr(`FAST_INTR_PAGE, `FIC_PENDING_OFFSET), 32'(pulse));
    // Bit 8 is still driven and survives its clear
    obi_write(reg_addr(`FAST_INTR_PAGE, `FIC_CLEAR_OFFSET), 32'(pulse), 4'hf, 1'b0);
    read_check("PENDING after clear", reg_addr(`FAST_INTR_PAGE, `FIC_PENDING_OFFSET),
               32'(held));
    check_fast_intr("fast_intr_o after clear", fast_intr_o, held & en);
    @(posedge clk_i);
    fast_intr_i <= '0;
    obi_write(reg_addr(`FAST_INTR_PAGE, `FIC_CLEAR_OFFSET), 32'(held), 4'hf, 1'b0);
    read_check("PENDING after release", reg_addr(`FAST_INTR_PAGE, `FIC_PENDING_OFFSET), '0);
    check_fast_intr("fast_intr_o after release", fast_intr_o, '0);
    read_check("ENABLE", reg_addr(`FAST_INTR_PAGE, `FIC_ENABLE_OFFSET), 32'(en));
  endtask

  task automatic test_unmapped();
    ao_periph_pkg::data_t got;
    obi_read(reg_addr(4'd5, 12'h000), 1'b1, got);
    check_data("unmapped read data", got, '0);
    obi_write(reg_addr(4'd5, `SOC_EXIT_VALUE_OFFSET), $random(seed), 4'hf, 1'b1);
    obi_write(reg_addr(4'hf, `SOC_EXIT_VALUE_OFFSET), $random(seed), 4'hf, 1'b1);
    check_data("exit_value_o after unmapped write", exit_value_o, exit_value_exp);
    read_check("EXIT_VALUE after unmapped write",
               reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALUE_OFFSET), exit_value_exp);
  endtask

  task automatic test_back_to_back();
    ao_periph_pkg::data_t value;
    value = $random(seed);
    obi_write(reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALUE_OFFSET), value, 4'hf, 1'b0);
    if (grant_wait != 0) begin
      abort_run("Back-to-back write was not granted at once");
    end
    read_check("EXIT_VALUE back to back", reg_addr(`SOC_CTRL_PAGE, `SOC_EXIT_VALUE_OFFSET),
               value);
    if (grant_wait != 0) begin
      abort_run("Back-to-back read was not granted at once");
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    abort_run($sformatf("Timeout: tests still running after %0d ns", TIMEOUT_NS));
  end

  initial begin
    seed          = 32'h9be2;
    grant_wait    = 0;
    rst_i         = 1'b1;
    slave_req_i   = 1'b0;
    slave_we_i    = 1'b0;
    slave_addr_i  = '0;
    slave_wdata_i = '0;
    slave_be_i    = '0;
    boot_select_i = 1'b1;
    fast_intr_i   = '0;
    cio_gpio_i    = 8'h5a;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    test_reset_state();
    test_soc_ctrl();
    test_gpio();
    test_fast_intr();
    test_unmapped();
    test_back_to_back();
    $display("test passed");
    $finish;
  end

endmodule
